// File: source/issue_pkg.sv
`default_nettype none

package issue_pkg;

   // Instruction field widths
   localparam int OPCODE_W = 32;
   localparam int PC_W = 32;
   localparam int IMM_W = 16;

   // Default wavefront count per compute unit, any value of 2 or more works
   localparam int DEF_WF_PER_CU = 8;

   // Outstanding LSU operations allowed per wavefront
   localparam int DEF_MEM_MAX_INFLIGHT = 3;

endpackage

`default_nettype wire

// File: source/issue_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// Current slot contents, one entry per wavefront
interface slot_if #(
   parameter int WF_PER_CU = issue_pkg::DEF_WF_PER_CU
);
   import issue_pkg::*;

   logic [WF_PER_CU-1:0] valid;
   logic [WF_PER_CU-1:0] is_lsu;
   logic [WF_PER_CU-1:0] is_branch;
   logic [WF_PER_CU-1:0][OPCODE_W-1:0] opcode;
   logic [WF_PER_CU-1:0][PC_W-1:0] pc;
   logic [WF_PER_CU-1:0][IMM_W-1:0] imm;

   modport source (output valid, is_lsu, is_branch, opcode, pc, imm);
   modport sink (input valid, is_lsu, is_branch, opcode, pc, imm);
endinterface

// Picks of this cycle, acted on at the next edge
interface grant_if #(
   parameter int WF_PER_CU = issue_pkg::DEF_WF_PER_CU
);
   localparam int WID_W = $clog2(WF_PER_CU);

   logic pick_alu;
   logic [WID_W-1:0] pick_alu_wfid;
   logic pick_alu_branch;
   logic pick_lsu;
   logic [WID_W-1:0] pick_lsu_wfid;

   modport arbiter (output pick_alu, pick_alu_wfid, pick_alu_branch, pick_lsu, pick_lsu_wfid);
   modport buffer (input pick_alu, pick_alu_wfid, pick_lsu, pick_lsu_wfid);
   modport tracker (input pick_alu, pick_alu_wfid, pick_alu_branch, pick_lsu, pick_lsu_wfid);
endinterface

`default_nettype wire

// File: source/instr_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module instr_buffer #(
   parameter int WF_PER_CU = issue_pkg::DEF_WF_PER_CU,
   localparam int WID_W = $clog2(WF_PER_CU)
) (
   input wire logic clk,
   input wire logic rst_n,
   input wire logic decode_valid,
   input wire logic [WID_W-1:0] decode_wfid,
   input wire logic decode_lsu,
   input wire logic decode_branch,
   input wire logic [issue_pkg::OPCODE_W-1:0] decode_opcode,
   input wire logic [issue_pkg::PC_W-1:0] decode_instr_pc,
   input wire logic [issue_pkg::IMM_W-1:0] decode_imm_value,
   slot_if.source slot,
   grant_if.buffer grant,
   output logic [WF_PER_CU-1:0] wave_valid_entries
);
   import issue_pkg::*;

   // Input flops
   logic f_valid;
   logic [WID_W-1:0] f_wfid;
   logic f_lsu;
   logic f_branch;
   logic [OPCODE_W-1:0] f_opcode;
   logic [PC_W-1:0] f_pc;
   logic [IMM_W-1:0] f_imm;

   // Slot storage
   logic [WF_PER_CU-1:0] valid_q;
   logic [WF_PER_CU-1:0] lsu_q;
   logic [WF_PER_CU-1:0] branch_q;
   logic [WF_PER_CU-1:0][OPCODE_W-1:0] opcode_q;
   logic [WF_PER_CU-1:0][PC_W-1:0] pc_q;
   logic [WF_PER_CU-1:0][IMM_W-1:0] imm_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         f_valid <= 1'b0;
      end else begin
         f_valid <= decode_valid;
      end
   end

   always_ff @(posedge clk) begin
      f_wfid <= decode_wfid;
      f_lsu <= decode_lsu;
      f_branch <= decode_branch;
      f_opcode <= decode_opcode;
      f_pc <= decode_instr_pc;
      f_imm <= decode_imm_value;
   end

   // Issued waves drop out, a new decode takes the slot
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q <= '0;
      end else begin
         if (grant.pick_alu)
            valid_q[grant.pick_alu_wfid] <= 1'b0;
         if (grant.pick_lsu)
            valid_q[grant.pick_lsu_wfid] <= 1'b0;
         if (f_valid)
            valid_q[f_wfid] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (f_valid) begin
         lsu_q[f_wfid] <= f_lsu;
         branch_q[f_wfid] <= f_branch;
         opcode_q[f_wfid] <= f_opcode;
         pc_q[f_wfid] <= f_pc;
         imm_q[f_wfid] <= f_imm;
      end
   end

   assign slot.valid = valid_q;
   assign slot.is_lsu = lsu_q;
   assign slot.is_branch = branch_q;
   assign slot.opcode = opcode_q;
   assign slot.pc = pc_q;
   assign slot.imm = imm_q;

   assign wave_valid_entries = valid_q;

endmodule

`default_nettype wire

// File: source/wave_wait.sv
`timescale 1ns/1ps
`default_nettype none

module wave_wait #(
   parameter int WF_PER_CU = issue_pkg::DEF_WF_PER_CU,
   parameter int MEM_MAX_INFLIGHT = issue_pkg::DEF_MEM_MAX_INFLIGHT,
   localparam int WID_W = $clog2(WF_PER_CU)
) (
   input wire logic clk,
   input wire logic rst_n,
   input wire logic salu_branch_en,
   input wire logic [WID_W-1:0] salu_branch_wfid,
   input wire logic lsu_done,
   input wire logic [WID_W-1:0] lsu_done_wfid,
   grant_if.tracker grant,
   output logic [WF_PER_CU-1:0] alu_block,
   output logic [WF_PER_CU-1:0] lsu_block
);
   localparam int CNT_W = $clog2(MEM_MAX_INFLIGHT + 1);

   logic f_branch_en;
   logic [WID_W-1:0] f_branch_wfid;
   logic f_done;
   logic [WID_W-1:0] f_done_wfid;

   logic [WF_PER_CU-1:0] pending_branch;
   logic [CNT_W-1:0] mem_cnt [WF_PER_CU];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         f_branch_en <= 1'b0;
         f_done <= 1'b0;
      end else begin
         f_branch_en <= salu_branch_en;
         f_done <= lsu_done;
      end
   end

   always_ff @(posedge clk) begin
      f_branch_wfid <= salu_branch_wfid;
      f_done_wfid <= lsu_done_wfid;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pending_branch <= '0;
         for (int w = 0; w < WF_PER_CU; w++)
            mem_cnt[w] <= '0;
      end else begin
         // Resolution first, a new branch pick overrides
         if (f_branch_en)
            pending_branch[f_branch_wfid] <= 1'b0;
         if (grant.pick_alu && grant.pick_alu_branch)
            pending_branch[grant.pick_alu_wfid] <= 1'b1;
         for (int w = 0; w < WF_PER_CU; w++) begin
            if (grant.pick_lsu && grant.pick_lsu_wfid == WID_W'(w)) begin
               if (!(f_done && f_done_wfid == WID_W'(w)))
                  mem_cnt[w] <= mem_cnt[w] + 1'b1;
            end else if (f_done && f_done_wfid == WID_W'(w)) begin
               mem_cnt[w] <= mem_cnt[w] - 1'b1;
            end
         end
      end
   end

   always_comb begin
      alu_block = pending_branch;
      for (int w = 0; w < WF_PER_CU; w++)
         lsu_block[w] = pending_branch[w] || (mem_cnt[w] == CNT_W'(MEM_MAX_INFLIGHT));
   end

endmodule

`default_nettype wire

// File: source/issue_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module issue_arbiter #(
   parameter int WF_PER_CU = issue_pkg::DEF_WF_PER_CU,
   localparam int WID_W = $clog2(WF_PER_CU)
) (
   input wire logic clk,
   input wire logic rst_n,
   input wire logic alu_ready,
   input wire logic lsu_ready,
   input wire logic [WF_PER_CU-1:0] alu_block,
   input wire logic [WF_PER_CU-1:0] lsu_block,
   slot_if.sink slot,
   grant_if.arbiter grant,
   output logic alu_select,
   output logic [WID_W-1:0] alu_wfid,
   output logic [issue_pkg::OPCODE_W-1:0] alu_opcode,
   output logic [issue_pkg::PC_W-1:0] alu_instr_pc,
   output logic [issue_pkg::IMM_W-1:0] alu_imm_value,
   output logic lsu_select,
   output logic [WID_W-1:0] lsu_wfid,
   output logic [issue_pkg::OPCODE_W-1:0] lsu_opcode,
   output logic [issue_pkg::PC_W-1:0] lsu_instr_pc,
   output logic [issue_pkg::IMM_W-1:0] lsu_imm_value
);
   logic [WF_PER_CU-1:0] alu_eligible;
   logic [WF_PER_CU-1:0] lsu_eligible;
   logic [WID_W-1:0] alu_last;
   logic [WID_W-1:0] lsu_last;
   logic [WID_W:0] alu_find;
   logic [WID_W:0] lsu_find;

   // First request after last, returned as {found, index}
   function automatic logic [WID_W:0] rr_find(input logic [WF_PER_CU-1:0] req,
                                              input logic [WID_W-1:0] last);
      logic [WID_W:0] result;
      int k;
      int idx;
      result = '0;
      for (k = WF_PER_CU; k >= 1; k--) begin
         idx = (int'(last) + k) % WF_PER_CU;
         if (req[idx])
            result = {1'b1, WID_W'(idx)};
      end
      return result;
   endfunction

   assign alu_eligible = slot.valid & ~slot.is_lsu & ~alu_block & {WF_PER_CU{alu_ready}};
   assign lsu_eligible = slot.valid & slot.is_lsu & ~lsu_block & {WF_PER_CU{lsu_ready}};

   assign alu_find = rr_find(alu_eligible, alu_last);
   assign lsu_find = rr_find(lsu_eligible, lsu_last);

   assign grant.pick_alu = alu_find[WID_W];
   assign grant.pick_alu_wfid = alu_find[WID_W-1:0];
   assign grant.pick_alu_branch = slot.is_branch[alu_find[WID_W-1:0]];
   assign grant.pick_lsu = lsu_find[WID_W];
   assign grant.pick_lsu_wfid = lsu_find[WID_W-1:0];

   // Search starts at wave 0 after reset
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         alu_last <= WID_W'(WF_PER_CU - 1);
         lsu_last <= WID_W'(WF_PER_CU - 1);
         alu_select <= 1'b0;
         lsu_select <= 1'b0;
      end else begin
         alu_select <= grant.pick_alu;
         lsu_select <= grant.pick_lsu;
         if (grant.pick_alu)
            alu_last <= grant.pick_alu_wfid;
         if (grant.pick_lsu)
            lsu_last <= grant.pick_lsu_wfid;
      end
   end

   always_ff @(posedge clk) begin
      if (grant.pick_alu) begin
         alu_wfid <= grant.pick_alu_wfid;
         alu_opcode <= slot.opcode[grant.pick_alu_wfid];
         alu_instr_pc <= slot.pc[grant.pick_alu_wfid];
         alu_imm_value <= slot.imm[grant.pick_alu_wfid];
      end
      if (grant.pick_lsu) begin
         lsu_wfid <= grant.pick_lsu_wfid;
         lsu_opcode <= slot.opcode[grant.pick_lsu_wfid];
         lsu_instr_pc <= slot.pc[grant.pick_lsu_wfid];
         lsu_imm_value <= slot.imm[grant.pick_lsu_wfid];
      end
   end

endmodule

`default_nettype wire

// File: source/issue_top.sv
`timescale 1ns/1ps
`default_nettype none

module issue_top #(
   parameter int WF_PER_CU = issue_pkg::DEF_WF_PER_CU,
   parameter int MEM_MAX_INFLIGHT = issue_pkg::DEF_MEM_MAX_INFLIGHT,
   localparam int WID_W = $clog2(WF_PER_CU)
) (
   input wire logic clk,
   input wire logic rst_n,
   input wire logic decode_valid,
   input wire logic [WID_W-1:0] decode_wfid,
   input wire logic decode_lsu,
   input wire logic decode_branch,
   input wire logic [issue_pkg::OPCODE_W-1:0] decode_opcode,
   input wire logic [issue_pkg::PC_W-1:0] decode_instr_pc,
   input wire logic [issue_pkg::IMM_W-1:0] decode_imm_value,
   input wire logic alu_ready,
   input wire logic lsu_ready,
   input wire logic salu_branch_en,
   input wire logic [WID_W-1:0] salu_branch_wfid,
   input wire logic lsu_done,
   input wire logic [WID_W-1:0] lsu_done_wfid,
   output logic alu_select,
   output logic [WID_W-1:0] alu_wfid,
   output logic [issue_pkg::OPCODE_W-1:0] alu_opcode,
   output logic [issue_pkg::PC_W-1:0] alu_instr_pc,
   output logic [issue_pkg::IMM_W-1:0] alu_imm_value,
   output logic lsu_select,
   output logic [WID_W-1:0] lsu_wfid,
   output logic [issue_pkg::OPCODE_W-1:0] lsu_opcode,
   output logic [issue_pkg::PC_W-1:0] lsu_instr_pc,
   output logic [issue_pkg::IMM_W-1:0] lsu_imm_value,
   output logic [WF_PER_CU-1:0] wave_valid_entries
);
   logic [WF_PER_CU-1:0] alu_block;
   logic [WF_PER_CU-1:0] lsu_block;

   slot_if #(.WF_PER_CU(WF_PER_CU)) slot_bus ();
   grant_if #(.WF_PER_CU(WF_PER_CU)) grant_bus ();

   instr_buffer #(.WF_PER_CU(WF_PER_CU)) u_buffer (
      .clk(clk),
      .rst_n(rst_n),
      .decode_valid(decode_valid),
      .decode_wfid(decode_wfid),
      .decode_lsu(decode_lsu),
      .decode_branch(decode_branch),
      .decode_opcode(decode_opcode),
      .decode_instr_pc(decode_instr_pc),
      .decode_imm_value(decode_imm_value),
      .slot(slot_bus.source),
      .grant(grant_bus.buffer),
      .wave_valid_entries(wave_valid_entries)
   );

   wave_wait #(
      .WF_PER_CU(WF_PER_CU),
      .MEM_MAX_INFLIGHT(MEM_MAX_INFLIGHT)
   ) u_wait (
      .clk(clk),
      .rst_n(rst_n),
      .salu_branch_en(salu_branch_en),
      .salu_branch_wfid(salu_branch_wfid),
      .lsu_done(lsu_done),
      .lsu_done_wfid(lsu_done_wfid),
      .grant(grant_bus.tracker),
      .alu_block(alu_block),
      .lsu_block(lsu_block)
   );

   issue_arbiter #(.WF_PER_CU(WF_PER_CU)) u_arbiter (
      .clk(clk),
      .rst_n(rst_n),
      .alu_ready(alu_ready),
      .lsu_ready(lsu_ready),
      .alu_block(alu_block),
      .lsu_block(lsu_block),
      .slot(slot_bus.sink),
      .grant(grant_bus.arbiter),
      .alu_select(alu_select),
      .alu_wfid(alu_wfid),
      .alu_opcode(alu_opcode),
      .alu_instr_pc(alu_instr_pc),
      .alu_imm_value(alu_imm_value),
      .lsu_select(lsu_select),
      .lsu_wfid(lsu_wfid),
      .lsu_opcode(lsu_opcode),
      .lsu_instr_pc(lsu_instr_pc),
      .lsu_imm_value(lsu_imm_value)
   );

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
   parameter real PERIOD_NS = 8.0
) (
   output logic clk
);
   initial clk = 1'b0;

   always #(PERIOD_NS / 2.0) clk = ~clk;

endmodule

`default_nettype wire

// File: bench/issue_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module issue_asserts #(
   parameter int WID_W = 3
) (
   input wire logic clk,
   input wire logic rst_n,
   input wire logic alu_ready,
   input wire logic lsu_ready,
   input wire logic alu_select,
   input wire logic lsu_select,
   input wire logic [WID_W-1:0] alu_wfid,
   input wire logic [WID_W-1:0] lsu_wfid
);
   // Selects are registered from picks gated by ready
   alu_ready_before_select: assert property (
      @(posedge clk) disable iff (!rst_n) alu_select |-> $past(alu_ready))
      else $error("alu_select without alu_ready in the previous cycle");

   lsu_ready_before_select: assert property (
      @(posedge clk) disable iff (!rst_n) lsu_select |-> $past(lsu_ready))
      else $error("lsu_select without lsu_ready in the previous cycle");

   // A wave holds one instruction, so it can not go to both units
   distinct_wfids: assert property (
      @(posedge clk) disable iff (!rst_n) (alu_select && lsu_select) |-> alu_wfid != lsu_wfid)
      else $error("alu and lsu selects share one wfid");

   quiet_in_reset: assert property (
      @(posedge clk) !rst_n |-> (!alu_select && !lsu_select))
      else $error("select high during reset");

endmodule

bind issue_top issue_asserts #(.WID_W($clog2(WF_PER_CU))) u_asserts (
   .clk(clk),
   .rst_n(rst_n),
   .alu_ready(alu_ready),
   .lsu_ready(lsu_ready),
   .alu_select(alu_select),
   .lsu_select(lsu_select),
   .alu_wfid(alu_wfid),
   .lsu_wfid(lsu_wfid)
);

`default_nettype wire

// File: bench/issue_tb.sv
`timescale 1ns/1ps
`default_nettype none

module issue_tb;
   import issue_pkg::*;

   localparam int WF = 8;
   localparam int WID_W = $clog2(WF);
   localparam int REC_W = WID_W + OPCODE_W + PC_W + IMM_W;

   logic clk;
   logic rst_n;
   logic decode_valid;
   logic [WID_W-1:0] decode_wfid;
   logic decode_lsu;
   logic decode_branch;
   logic [OPCODE_W-1:0] decode_opcode;
   logic [PC_W-1:0] decode_instr_pc;
   logic [IMM_W-1:0] decode_imm_value;
   logic alu_ready;
   logic lsu_ready;
   logic salu_branch_en;
   logic [WID_W-1:0] salu_branch_wfid;
   logic lsu_done;
   logic [WID_W-1:0] lsu_done_wfid;
   logic alu_select;
   logic [WID_W-1:0] alu_wfid;
   logic [OPCODE_W-1:0] alu_opcode;
   logic [PC_W-1:0] alu_instr_pc;
   logic [IMM_W-1:0] alu_imm_value;
   logic lsu_select;
   logic [WID_W-1:0] lsu_wfid;
   logic [OPCODE_W-1:0] lsu_opcode;
   logic [PC_W-1:0] lsu_instr_pc;
   logic [IMM_W-1:0] lsu_imm_value;
   logic [WF-1:0] wave_valid_entries;

   // Issued instructions as {wfid, opcode, pc, imm}
   logic [REC_W-1:0] alu_q [$];
   logic [REC_W-1:0] lsu_q [$];

   logic [31:0] rng_state;
   int error_count;
   int tests_run;
   int tests_bad;

   tb_clock #(.PERIOD_NS(8.0)) u_clock (.clk(clk));

   issue_top #(.WF_PER_CU(WF), .MEM_MAX_INFLIGHT(3)) DUT (
      .clk(clk),
      .rst_n(rst_n),
      .decode_valid(decode_valid),
      .decode_wfid(decode_wfid),
      .decode_lsu(decode_lsu),
      .decode_branch(decode_branch),
      .decode_opcode(decode_opcode),
      .decode_instr_pc(decode_instr_pc),
      .decode_imm_value(decode_imm_value),
      .alu_ready(alu_ready),
      .lsu_ready(lsu_ready),
      .salu_branch_en(salu_branch_en),
      .salu_branch_wfid(salu_branch_wfid),
      .lsu_done(lsu_done),
      .lsu_done_wfid(lsu_done_wfid),
      .alu_select(alu_select),
      .alu_wfid(alu_wfid),
      .alu_opcode(alu_opcode),
      .alu_instr_pc(alu_instr_pc),
      .alu_imm_value(alu_imm_value),
      .lsu_select(lsu_select),
      .lsu_wfid(lsu_wfid),
      .lsu_opcode(lsu_opcode),
      .lsu_instr_pc(lsu_instr_pc),
      .lsu_imm_value(lsu_imm_value),
      .wave_valid_entries(wave_valid_entries)
   );

   // One record per select pulse, taken mid-cycle
   always @(negedge clk) begin
      if (rst_n) begin
         if (alu_select)
            alu_q.push_back({alu_wfid, alu_opcode, alu_instr_pc, alu_imm_value});
         if (lsu_select)
            lsu_q.push_back({lsu_wfid, lsu_opcode, lsu_instr_pc, lsu_imm_value});
      end
   end

   function logic [31:0] xorshift();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function int issued(input logic on_lsu);
      return on_lsu ? lsu_q.size() : alu_q.size();
   endfunction

   task automatic step();
      @(posedge clk);
      #1;
   endtask

   task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
      if (got !== exp) begin
         $display("FAIL t=%0t %s got %0h expected %0h", $time, name, got, exp);
         error_count++;
      end
   endtask

   task automatic report_error(input string msg);
      $display("ERROR t=%0t %s", $time, msg);
      error_count++;
   endtask

   task automatic finish_test(input string name, input int errs_before);
      int errs;
      errs = error_count - errs_before;
      tests_run++;
      if (errs != 0)
         tests_bad++;
      $display("%-16s %0d error(s)", name, errs);
   endtask

   task automatic load_instr(input int wfid, input logic lsu, input logic branch,
                             output logic [REC_W-1:0] rec);
      logic [OPCODE_W-1:0] op;
      logic [PC_W-1:0] pc;
      logic [IMM_W-1:0] imm;
      op = xorshift();
      pc = xorshift();
      imm = IMM_W'(xorshift());
      rec = {WID_W'(wfid), op, pc, imm};
      decode_valid = 1'b1;
      decode_wfid = WID_W'(wfid);
      decode_lsu = lsu;
      decode_branch = branch;
      decode_opcode = op;
      decode_instr_pc = pc;
      decode_imm_value = imm;
      step();
      decode_valid = 1'b0;
   endtask

   task automatic wait_issues(input logic on_lsu, input int n, input int limit);
      int cycles;
      cycles = 0;
      while (issued(on_lsu) < n && cycles < limit) begin
         step();
         cycles++;
      end
      if (issued(on_lsu) < n)
         report_error($sformatf("timeout waiting for %0d %s issue(s)", n, on_lsu ? "lsu" : "alu"));
   endtask

   task automatic wait_valid(input logic [WF-1:0] mask, input int limit);
      int cycles;
      cycles = 0;
      while ((wave_valid_entries & mask) != mask && cycles < limit) begin
         step();
         cycles++;
      end
      if ((wave_valid_entries & mask) != mask)
         report_error($sformatf("timeout waiting for valid entries %0h", mask));
   endtask

   task automatic test_reset_state();
      int e0;
      e0 = error_count;
      check("alu_select", 128'(alu_select), 128'(0));
      check("lsu_select", 128'(lsu_select), 128'(0));
      check("wave_valid_entries", 128'(wave_valid_entries), 128'(0));
      finish_test("reset_state", e0);
   endtask

   task automatic test_basic_issue();
      int e0;
      logic [REC_W-1:0] alu_rec;
      logic [REC_W-1:0] lsu_rec;
      e0 = error_count;
      alu_q.delete();
      lsu_q.delete();
      alu_ready = 1'b1;
      lsu_ready = 1'b1;
      // Last ALU grant on wave 7 restarts the ALU search at wave 0
      load_instr(7, 1'b0, 1'b0, alu_rec);
      load_instr(5, 1'b1, 1'b0, lsu_rec);
      wait_issues(1'b0, 1, 20);
      wait_issues(1'b1, 1, 20);
      repeat (5) step();
      check("alu issue count", 128'(alu_q.size()), 128'(1));
      check("lsu issue count", 128'(lsu_q.size()), 128'(1));
      if (alu_q.size() > 0)
         check("alu issue record", 128'(alu_q[0]), 128'(alu_rec));
      if (lsu_q.size() > 0)
         check("lsu issue record", 128'(lsu_q[0]), 128'(lsu_rec));
      check("wave_valid_entries", 128'(wave_valid_entries), 128'(0));
      finish_test("basic_issue", e0);
   endtask

   task automatic test_round_robin();
      int e0;
      logic [REC_W-1:0] recs [WF];
      e0 = error_count;
      alu_q.delete();
      alu_ready = 1'b0;
      for (int w = 0; w < WF; w++)
         load_instr(w, 1'b0, 1'b0, recs[w]);
      wait_valid('1, 10);
      alu_ready = 1'b1;
      wait_issues(1'b0, WF, 40);
      repeat (3) step();
      check("alu issue count", 128'(alu_q.size()), 128'(WF));
      for (int w = 0; w < WF; w++) begin
         if (w < alu_q.size())
            check($sformatf("alu issue record %0d", w), 128'(alu_q[w]), 128'(recs[w]));
      end
      // Last grant on wave 3, so wave 6 goes before wave 1
      alu_q.delete();
      load_instr(3, 1'b0, 1'b0, recs[3]);
      wait_issues(1'b0, 1, 20);
      alu_ready = 1'b0;
      load_instr(1, 1'b0, 1'b0, recs[1]);
      load_instr(6, 1'b0, 1'b0, recs[6]);
      wait_valid(WF'('h42), 10);
      alu_ready = 1'b1;
      wait_issues(1'b0, 3, 20);
      repeat (3) step();
      check("alu issue count after wrap", 128'(alu_q.size()), 128'(3));
      if (alu_q.size() == 3) begin
         check("alu issue record wave 3", 128'(alu_q[0]), 128'(recs[3]));
         check("alu issue record wave 6", 128'(alu_q[1]), 128'(recs[6]));
         check("alu issue record wave 1", 128'(alu_q[2]), 128'(recs[1]));
      end
      finish_test("round_robin", e0);
   endtask

   task automatic test_back_pressure();
      int e0;
      logic held;
      logic [REC_W-1:0] rec;
      e0 = error_count;
      lsu_q.delete();
      lsu_ready = 1'b0;
      load_instr(4, 1'b1, 1'b0, rec);
      wait_valid(WF'(1) << 4, 10);
      held = 1'b1;
      repeat (20) begin
         step();
         if (!wave_valid_entries[4])
            held = 1'b0;
      end
      check("lsu issue count while stalled", 128'(lsu_q.size()), 128'(0));
      check("wave_valid_entries[4] held", 128'(held), 128'(1));
      lsu_ready = 1'b1;
      wait_issues(1'b1, 1, 20);
      repeat (5) step();
      check("lsu issue count", 128'(lsu_q.size()), 128'(1));
      if (lsu_q.size() > 0)
         check("lsu issue record", 128'(lsu_q[0]), 128'(rec));
      check("wave_valid_entries[4]", 128'(wave_valid_entries[4]), 128'(0));
      finish_test("back_pressure", e0);
   endtask

   task automatic test_branch_wait();
      int e0;
      logic [REC_W-1:0] br_rec;
      logic [REC_W-1:0] next_rec;
      e0 = error_count;
      alu_q.delete();
      alu_ready = 1'b1;
      load_instr(2, 1'b0, 1'b1, br_rec);
      wait_issues(1'b0, 1, 20);
      load_instr(2, 1'b0, 1'b0, next_rec);
      repeat (30) step();
      check("alu issue count with branch pending", 128'(alu_q.size()), 128'(1));
      salu_branch_en = 1'b1;
      salu_branch_wfid = WID_W'(2);
      step();
      salu_branch_en = 1'b0;
      wait_issues(1'b0, 2, 20);
      if (alu_q.size() > 0)
         check("alu branch record", 128'(alu_q[0]), 128'(br_rec));
      if (alu_q.size() > 1)
         check("alu record after branch", 128'(alu_q[1]), 128'(next_rec));
      finish_test("branch_wait", e0);
   endtask

   task automatic test_memory_wait();
      int e0;
      logic [REC_W-1:0] recs [4];
      e0 = error_count;
      lsu_q.delete();
      lsu_ready = 1'b1;
      for (int k = 0; k < 3; k++) begin
         load_instr(1, 1'b1, 1'b0, recs[k]);
         wait_issues(1'b1, k + 1, 20);
      end
      load_instr(1, 1'b1, 1'b0, recs[3]);
      repeat (30) step();
      check("lsu issue count at limit", 128'(lsu_q.size()), 128'(3));
      lsu_done = 1'b1;
      lsu_done_wfid = WID_W'(1);
      step();
      lsu_done = 1'b0;
      wait_issues(1'b1, 4, 20);
      for (int k = 0; k < 4; k++) begin
         if (k < lsu_q.size())
            check($sformatf("lsu issue record %0d", k), 128'(lsu_q[k]), 128'(recs[k]));
      end
      finish_test("memory_wait", e0);
   endtask

   initial begin
      rng_state = 32'd98528;
      error_count = 0;
      tests_run = 0;
      tests_bad = 0;
      rst_n = 1'b0;
      decode_valid = 1'b0;
      decode_wfid = '0;
      decode_lsu = 1'b0;
      decode_branch = 1'b0;
      decode_opcode = '0;
      decode_instr_pc = '0;
      decode_imm_value = '0;
      alu_ready = 1'b0;
      lsu_ready = 1'b0;
      salu_branch_en = 1'b0;
      salu_branch_wfid = '0;
      lsu_done = 1'b0;
      lsu_done_wfid = '0;
      repeat (10) @(posedge clk);
      #1;
      rst_n = 1'b1;
      step();
      test_reset_state();
      test_basic_issue();
      test_round_robin();
      test_back_pressure();
      test_branch_wait();
      test_memory_wait();
      $display("tests %0d, tests with errors %0d, errors %0d", tests_run, tests_bad, error_count);
      if (error_count == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

   // Last resort if a wait loop is broken
   initial begin
      #100000;
      $display("simulation ran past its time limit");
      $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: build.f
source/issue_pkg.sv
source/issue_ifs.sv
source/instr_buffer.sv
source/wave_wait.sv
source/issue_arbiter.sv
source/issue_top.sv
bench/tb_clock.sv
bench/issue_asserts.sv
bench/issue_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module issue_tb -f build.f -o issue_sim

# The log decides the result
./obj_dir/issue_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "test passed" sim.log; then
   exit 0
fi
exit 1
